/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_dirpint
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

SRCS    = $(shell grep -v '^+' $(FILELIST))
HDRS    = $(wildcard design/*.svh)
SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up on a line of its own
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/dirpint.sv */
`timescale 1ns/10ps

module dirpint (
  input  logic                            clk,
  input  logic                            rst_n,

  input  rt_pkg::ray_vec_t                wdata_dirpint,
  input  rt_pkg::ray_id_t                 waddr_dirpint,
  input  logic                            we_dirpint,

  input  rt_pkg::scache_to_shader_t       scache_to_dirpint_data,
  input  logic                            scache_to_dirpint_valid,
  output logic                            scache_to_dirpint_stall,

  input  logic                            dirpint_to_calcdirect_stall,
  output rt_pkg::dirpint_to_calc_direct_t dirpint_to_calc_direct_data,
  output logic                            dirpint_to_calc_direct_valid,

  input  logic                            dirpint_to_sendreflect_stall,
  output rt_pkg::dirpint_to_sendreflect_t dirpint_to_sendreflect_data,
  output logic                            dirpint_to_sendreflect_valid
);

  rt_pkg::shade_req_t     pipe_in;
  rt_pkg::shade_req_t     pipe_out;
  logic                   pipe_ds_valid;
  logic [1:0]             num_left_in_fifo;
  rt_pkg::ray_vec_t       rd_ray;
  rt_pkg::dirpint_entry_t fifo_in;
  rt_pkg::dirpint_entry_t fifo_out;
  logic                   fifo_we;
  logic                   fifo_re;
  logic                   fifo_empty;
  logic                   need_reflect;
  logic                   ds_blocked;

  // truncated floats regain their width as zero low mantissa bits
  function automatic rt_pkg::float32_t widen24(input rt_pkg::float24_t f);
    return {f, 8'h00};
  endfunction

  function automatic rt_pkg::vector_t widen_vec(input rt_pkg::vector24_t v);
    rt_pkg::vector_t r;
    r.x = widen24(v.x);
    r.y = widen24(v.y);
    r.z = widen24(v.z);
    return r;
  endfunction

  ray_store ray_store_inst (
    .clk,
    .wraddress (waddr_dirpint),
    .data      (wdata_dirpint),
    .wren      (we_dirpint),
    .rdaddress (pipe_out.ray_id), // looked up as the request leaves the pipe
    .q         (rd_ray)
  );

  always_comb begin
    pipe_in.ray_id    = scache_to_dirpint_data.ray_id;
    pipe_in.normal    = scache_to_dirpint_data.normal;
    pipe_in.f_color   = scache_to_dirpint_data.f_color;
    pipe_in.spec      = scache_to_dirpint_data.spec;
    pipe_in.is_miss   = scache_to_dirpint_data.is_miss;
    pipe_in.is_shadow = scache_to_dirpint_data.is_shadow;
    pipe_in.is_last   = scache_to_dirpint_data.is_last;
  end

  pipe_valid_stall pipe_inst (
    .clk,
    .rst_n,
    .us_valid         (scache_to_dirpint_valid),
    .us_data          (pipe_in),
    .us_stall         (scache_to_dirpint_stall),
    .ds_valid         (pipe_ds_valid),
    .ds_data          (pipe_out),
    .num_left_in_fifo (num_left_in_fifo)
  );

  assign fifo_in.req = pipe_out;
  assign fifo_in.ray = rd_ray;

  // every item leaving the pipe already has a queue slot
  assign fifo_we = pipe_ds_valid;

  ray_fifo fifo_inst (
    .clk,
    .rst_n,
    .we               (fifo_we),
    .data_in          (fifo_in),
    .re               (fifo_re),
    .data_out         (fifo_out),
    .empty            (fifo_empty),
    .full             (),
    .num_left_in_fifo (num_left_in_fifo)
  );

  // shadow rays that are not the last also go to the reflection sender
  assign need_reflect = fifo_out.req.is_shadow & ~fifo_out.req.is_last;

  assign ds_blocked = ~fifo_empty & (dirpint_to_calcdirect_stall |
                      (dirpint_to_sendreflect_stall & need_reflect));

  assign dirpint_to_calc_direct_valid = ~fifo_empty & ~ds_blocked;
  assign dirpint_to_sendreflect_valid = dirpint_to_calc_direct_valid & need_reflect;
  assign fifo_re                      = dirpint_to_calc_direct_valid;

  always_comb begin
    dirpint_to_calc_direct_data.ray_id    = fifo_out.req.ray_id;
    dirpint_to_calc_direct_data.k         = widen24(fifo_out.req.f_color);
    dirpint_to_calc_direct_data.n         = widen_vec(fifo_out.req.normal);
    dirpint_to_calc_direct_data.p_int     = fifo_out.ray.p_int;
    dirpint_to_calc_direct_data.spec      = fifo_out.req.spec;
    dirpint_to_calc_direct_data.is_miss   = fifo_out.req.is_miss;
    dirpint_to_calc_direct_data.is_shadow = fifo_out.req.is_shadow;
    dirpint_to_calc_direct_data.is_last   = fifo_out.req.is_last;
  end

  always_comb begin
    dirpint_to_sendreflect_data.ray_id = fifo_out.req.ray_id;
    dirpint_to_sendreflect_data.normal = widen_vec(fifo_out.req.normal);
    dirpint_to_sendreflect_data.p_int  = fifo_out.ray.p_int;
    dirpint_to_sendreflect_data.dir    = fifo_out.ray.dir;
  end

endmodule

/* design/pipe_valid_stall.sv */
`timescale 1ns/10ps
`include "rt_config.svh"

module pipe_valid_stall (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               us_valid,
  input  rt_pkg::shade_req_t us_data,
  output logic               us_stall,
  output logic               ds_valid,
  output rt_pkg::shade_req_t ds_data,
  input  logic [1:0]         num_left_in_fifo
);

  localparam int DEPTH = `PIPE_DEPTH;
  localparam int CNT_W = $clog2(DEPTH + 2);

  logic [DEPTH-1:0]   valid_q;
  rt_pkg::shade_req_t data_q [DEPTH];
  logic [CNT_W-1:0]   in_flight;
  logic [CNT_W-1:0]   demand;
  logic               accept;

  // every item already in a stage holds a queue slot, as does the new one
  always_comb begin
    in_flight = CNT_W'($countones(valid_q));
    demand    = in_flight + CNT_W'(us_valid);
    us_stall  = demand > CNT_W'(num_left_in_fifo);
  end

  assign accept = us_valid & ~us_stall;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= accept;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // payload just shifts along behind the valid bits
  always_ff @(posedge clk) begin
    data_q[0] <= us_data;
    for (int i = 1; i < DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign ds_valid = valid_q[DEPTH-1];
  assign ds_data  = data_q[DEPTH-1];

endmodule

/* design/ray_fifo.sv */
`timescale 1ns/10ps
`include "rt_config.svh"

module ray_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   we,
  input  rt_pkg::dirpint_entry_t data_in,
  input  logic                   re,
  output rt_pkg::dirpint_entry_t data_out,
  output logic                   empty,
  output logic                   full,
  output logic [1:0]             num_left_in_fifo
);

  localparam logic [1:0] DEPTH = 2'(`FIFO_DEPTH);

  rt_pkg::dirpint_entry_t mem [`FIFO_DEPTH];

  logic [1:0] wr_ptr;
  logic [1:0] rd_ptr;
  logic [1:0] count;

  function automatic logic [1:0] next_ptr(input logic [1:0] ptr);
    logic [1:0] nxt;
    if (ptr == DEPTH - 2'd1) begin
      nxt = 2'd0;
    end else begin
      nxt = ptr + 2'd1;
    end
    return nxt;
  endfunction

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= 2'd0;
      rd_ptr <= 2'd0;
      count  <= 2'd0;
    end else begin
      if (we) wr_ptr <= next_ptr(wr_ptr);
      if (re) rd_ptr <= next_ptr(rd_ptr);
      case ({we, re})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count; // idle, or a push and a pop together
      endcase
    end
  end

  assign data_out         = mem[rd_ptr]; // head is always on the output
  assign empty            = (count == 2'd0);
  assign full             = (count == DEPTH);
  assign num_left_in_fifo = DEPTH - count;

endmodule

/* design/ray_store.sv */
`timescale 1ns/10ps
`include "rt_config.svh"

module ray_store (
  input  logic             clk,
  input  rt_pkg::ray_id_t  wraddress,
  input  rt_pkg::ray_vec_t data,
  input  logic             wren,
  input  rt_pkg::ray_id_t  rdaddress,
  output rt_pkg::ray_vec_t q
);

  localparam int NUM_RAYS = 1 << `RAY_ID_W;

  rt_pkg::ray_vec_t mem [NUM_RAYS];

  always_ff @(posedge clk) begin
    if (wren) begin
      mem[wraddress] <= data;
    end
  end

  // asynchronous read so the word is ready in the same cycle the
  // pipeline presents its ray ID
  assign q = mem[rdaddress];

endmodule

/* design/rt_config.svh */
`ifndef RT_CONFIG_SVH
`define RT_CONFIG_SVH

// ray IDs index the 512-entry ray store
`define RAY_ID_W 9

// register stages between the request port and the queue
`define PIPE_DEPTH 2

// the free-slot count is carried on 2 bits, so keep this at 3 or below
`define FIFO_DEPTH 3

`endif

/* design/rt_pkg.sv */
`include "rt_config.svh"

package rt_pkg;

  typedef logic [`RAY_ID_W-1:0] ray_id_t;

  // truncated floats, the low mantissa bits are dropped
  typedef logic [15:0] float16_t;
  typedef logic [23:0] float24_t;
  typedef logic [31:0] float32_t;

  typedef struct packed {
    float32_t x;
    float32_t y;
    float32_t z;
  } vector_t;

  typedef struct packed {
    float24_t x;
    float24_t y;
    float24_t z;
  } vector24_t;

  typedef struct packed {
    vector_t p_int; // intersection point
    vector_t dir;
  } ray_vec_t;

  typedef struct packed {
    ray_id_t   ray_id;
    vector24_t normal;
    float24_t  f_color;
    float16_t  spec;
    logic      is_miss;
    logic      is_shadow;
    logic      is_last;
  } scache_to_shader_t;

  typedef struct packed {
    ray_id_t   ray_id;
    vector24_t normal;
    float24_t  f_color;
    float16_t  spec;
    logic      is_miss;
    logic      is_shadow;
    logic      is_last;
  } shade_req_t;

  typedef struct packed {
    shade_req_t req;
    ray_vec_t   ray;
  } dirpint_entry_t;

  typedef struct packed {
    ray_id_t  ray_id;
    float32_t k; // surface colour
    vector_t  n; // surface normal
    vector_t  p_int;
    float16_t spec;
    logic     is_miss;
    logic     is_shadow;
    logic     is_last;
  } dirpint_to_calc_direct_t;

  typedef struct packed {
    ray_id_t ray_id;
    vector_t normal;
    vector_t p_int;
    vector_t dir;
  } dirpint_to_sendreflect_t;

endpackage

/* sim.f */
+incdir+design
design/rt_pkg.sv
design/ray_store.sv
design/pipe_valid_stall.sv
design/ray_fifo.sv
design/dirpint.sv
sim/tb_dirpint.sv

/* sim/tb_dirpint.sv */
`timescale 1ns/10ps

module tb_dirpint;

  localparam int NUM_RAYS   = 1 << $bits(rt_pkg::ray_id_t);
  localparam int NUM_REQ    = 400;
  localparam int TIMEOUT_NS = (NUM_REQ + 8) * 20 * 20 + (NUM_RAYS + 200) * 20;

  logic                            clk;
  logic                            rst_n;
  rt_pkg::ray_vec_t                wdata_dirpint;
  rt_pkg::ray_id_t                 waddr_dirpint;
  logic                            we_dirpint;
  rt_pkg::scache_to_shader_t       scache_to_dirpint_data;
  logic                            scache_to_dirpint_valid;
  logic                            scache_to_dirpint_stall;
  logic                            dirpint_to_calcdirect_stall;
  rt_pkg::dirpint_to_calc_direct_t dirpint_to_calc_direct_data;
  logic                            dirpint_to_calc_direct_valid;
  logic                            dirpint_to_sendreflect_stall;
  rt_pkg::dirpint_to_sendreflect_t dirpint_to_sendreflect_data;
  logic                            dirpint_to_sendreflect_valid;

  integer seed = 32'haee09010;
  int     mismatch_count = 0;
  int     fail_count = 0;
  logic [1:0] stall_mode = 2'd0; // 0 none, 1 random, 2 hold calc_direct off

  rt_pkg::ray_vec_t                shadow [NUM_RAYS];
  rt_pkg::dirpint_to_calc_direct_t exp_calc [$];
  rt_pkg::dirpint_to_sendreflect_t exp_refl [$];

  dirpint dirpint_inst (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic rt_pkg::ray_vec_t rand_ray();
    return {$random(seed), $random(seed), $random(seed),
            $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic rt_pkg::scache_to_shader_t rand_request();
    rt_pkg::scache_to_shader_t r;
    r.ray_id    = rt_pkg::ray_id_t'($random(seed));
    r.normal.x  = rt_pkg::float24_t'($random(seed));
    r.normal.y  = rt_pkg::float24_t'($random(seed));
    r.normal.z  = rt_pkg::float24_t'($random(seed));
    r.f_color   = rt_pkg::float24_t'($random(seed));
    r.spec      = rt_pkg::float16_t'($random(seed));
    r.is_miss   = (($random(seed) & 3) == 0);
    r.is_shadow = (($random(seed) & 1) == 0);
    r.is_last   = (($random(seed) & 3) == 0);
    return r;
  endfunction

  // expected records come from the shadow store plus zero-extended low mantissa bits
  task automatic push_expected(input rt_pkg::scache_to_shader_t req);
    rt_pkg::dirpint_to_calc_direct_t c;
    rt_pkg::dirpint_to_sendreflect_t r;
    c.ray_id    = req.ray_id;
    c.k         = {req.f_color, 8'h00};
    c.n         = {req.normal.x, 8'h00, req.normal.y, 8'h00, req.normal.z, 8'h00};
    c.p_int     = shadow[req.ray_id].p_int;
    c.spec      = req.spec;
    c.is_miss   = req.is_miss;
    c.is_shadow = req.is_shadow;
    c.is_last   = req.is_last;
    exp_calc.push_back(c);
    if (req.is_shadow && !req.is_last) begin
      r.ray_id = req.ray_id;
      r.normal = c.n;
      r.p_int  = shadow[req.ray_id].p_int;
      r.dir    = shadow[req.ray_id].dir;
      exp_refl.push_back(r);
    end
  endtask

  task automatic write_ray(input int addr);
    rt_pkg::ray_vec_t v;
    v = rand_ray();
    @(posedge clk);
    we_dirpint    <= 1'b1;
    waddr_dirpint <= rt_pkg::ray_id_t'(addr);
    wdata_dirpint <= v;
    shadow[addr] = v;
  endtask

  // returns once the request will be taken on the next rising edge
  task automatic send_request(input rt_pkg::scache_to_shader_t req, input int gap);
    int i;
    for (i = 0; i < gap; i++) begin
      @(posedge clk);
      scache_to_dirpint_valid <= 1'b0;
    end
    @(posedge clk);
    scache_to_dirpint_valid <= 1'b1;
    scache_to_dirpint_data  <= req;
    @(negedge clk);
    while (scache_to_dirpint_stall) @(negedge clk);
  endtask

  task automatic wait_drained();
    while (exp_calc.size() != 0) @(negedge clk);
    repeat (5) @(negedge clk);
  endtask

  always @(posedge clk) begin
    if (!rst_n || stall_mode == 2'd0) begin
      dirpint_to_calcdirect_stall  <= 1'b0;
      dirpint_to_sendreflect_stall <= 1'b0;
    end else if (stall_mode == 2'd1) begin
      dirpint_to_calcdirect_stall  <= (($random(seed) & 3) == 0);
      dirpint_to_sendreflect_stall <= (($random(seed) & 3) == 0);
    end else begin
      dirpint_to_calcdirect_stall  <= 1'b1;
      dirpint_to_sendreflect_stall <= 1'b0;
    end
  end

  // inputs only move on rising edges, so the falling edge sees settled values
  always @(negedge clk) begin
    if (rst_n) begin
      if (scache_to_dirpint_valid && !scache_to_dirpint_stall) begin
        push_expected(scache_to_dirpint_data);
      end
      if (dirpint_to_calc_direct_valid && dirpint_to_calcdirect_stall) begin
        fail_count++;
        $display("calc_direct valid was high while its stall was high at %0t", $time);
      end
      if (dirpint_to_sendreflect_valid && dirpint_to_sendreflect_stall) begin
        fail_count++;
        $display("sendreflect valid was high while its stall was high at %0t", $time);
      end
      if (dirpint_to_calc_direct_valid) begin
        if (exp_calc.size() == 0) begin
          fail_count++;
          $display("calc_direct delivered a record with no request outstanding at %0t", $time);
        end else begin
          if (dirpint_to_calc_direct_data !== exp_calc[0]) begin
            mismatch_count++;
            $display("Mismatch at %0t: calc_direct record got %h expected %h",
                     $time, dirpint_to_calc_direct_data, exp_calc[0]);
          end
          if (exp_calc[0].is_shadow && !exp_calc[0].is_last) begin
            if (!dirpint_to_sendreflect_valid) begin
              mismatch_count++;
              $display("Mismatch at %0t: sendreflect valid low for ray %0d",
                       $time, exp_calc[0].ray_id);
            end else if (dirpint_to_sendreflect_data !== exp_refl[0]) begin
              mismatch_count++;
              $display("Mismatch at %0t: sendreflect record got %h expected %h",
                       $time, dirpint_to_sendreflect_data, exp_refl[0]);
            end
            void'(exp_refl.pop_front());
          end else if (dirpint_to_sendreflect_valid) begin
            mismatch_count++;
            $display("Mismatch at %0t: sendreflect valid high for ray %0d",
                     $time, exp_calc[0].ray_id);
          end
          void'(exp_calc.pop_front());
        end
      end else if (dirpint_to_sendreflect_valid) begin
        mismatch_count++;
        $display("Mismatch at %0t: sendreflect valid without calc_direct valid", $time);
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("tests failed");
    $finish;
  end

  initial begin
    rst_n                        = 1'b0;
    we_dirpint                   = 1'b0;
    waddr_dirpint                = '0;
    wdata_dirpint                = '0;
    scache_to_dirpint_valid      = 1'b0;
    scache_to_dirpint_data       = '0;
    dirpint_to_calcdirect_stall  = 1'b0;
    dirpint_to_sendreflect_stall = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (dirpint_to_calc_direct_valid || dirpint_to_sendreflect_valid ||
        scache_to_dirpint_stall) begin
      fail_count++;
      $display("an output valid or the request stall was high right after reset");
    end

    for (int a = 0; a < NUM_RAYS; a++) begin
      write_ray(a);
    end
    @(posedge clk);
    we_dirpint <= 1'b0;

    // random requests against random consumer back-pressure
    stall_mode <= 2'd1;
    for (int n = 0; n < NUM_REQ; n++) begin
      send_request(rand_request(), (($random(seed) & 7) == 0) ? 1 : 0);
    end
    @(posedge clk);
    scache_to_dirpint_valid <= 1'b0;
    stall_mode              <= 2'd0;
    wait_drained();

    // hold calc_direct off so the queue and pipe fill up
    @(posedge clk);
    stall_mode <= 2'd2;
    for (int n = 0; n < 3; n++) begin
      send_request(rand_request(), 0);
    end
    @(posedge clk);
    scache_to_dirpint_data <= rand_request();
    repeat (16) begin
      @(negedge clk);
      if (!scache_to_dirpint_stall) begin
        fail_count++;
        $display("request stall stayed low with three requests outstanding at %0t", $time);
      end
    end
    @(posedge clk);
    stall_mode <= 2'd0;
    @(negedge clk);
    while (scache_to_dirpint_stall) @(negedge clk);
    @(posedge clk);
    scache_to_dirpint_valid <= 1'b0;
    wait_drained();

    if (exp_refl.size() != 0) begin
      fail_count++;
      $display("%0d sendreflect records were never delivered", exp_refl.size());
    end
    $display("mismatches: %0d, other errors: %0d", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
